/* src/aluPkg.sv */
// Shared opcodes, ALU operation codes and instruction/control types, imported by every stage module
package aluPkg;

    localparam int INSTR_WIDTH = 16;               // Instruction word width
    localparam int IMM_WIDTH   = INSTR_WIDTH - 11; // Opcode, rs and rd take 11 bits

    // ALU operation, same encoding as the old Oper input
    typedef enum logic [2:0] {
        OP_ROL = 3'b000, // Rotate left
        OP_SLL = 3'b001, // Shift left logical
        OP_SRA = 3'b010, // Shift right arithmetic
        OP_SRL = 3'b011, // Shift right logical
        OP_ADD = 3'b100,
        OP_AND = 3'b101,
        OP_OR  = 3'b110, // Unused by the instruction set
        OP_XOR = 3'b111
    } aluOp_e;

    typedef enum logic [4:0] {
        OPC_ADDI   = 5'b01000,
        OPC_SUBI   = 5'b01001, // Imm minus rs
        OPC_XORI   = 5'b01010,
        OPC_ANDNI  = 5'b01011, // Rs and not imm
        OPC_ROLI   = 5'b10100,
        OPC_SLLI   = 5'b10101,
        OPC_SRAI   = 5'b10110,
        OPC_SRLI   = 5'b10111,
        OPC_SHIFTR = 5'b11010, // Func picks rol/sll/sra/srl
        OPC_ALUR   = 5'b11011  // Func picks add/sub/xor/andn
    } opcode_e;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;   // Source A
        logic [2:0] rt;   // Source B
        logic [2:0] rd;   // Destination
        logic [1:0] func; // Minor op
    } rFmt_t;

    typedef struct packed {
        logic [4:0]           opcode;
        logic [2:0]           rs;
        logic [2:0]           rd;
        logic [IMM_WIDTH-1:0] imm; // Raw immediate
    } iFmt_t;

    // One instruction word, two decodings
    typedef union packed {
        rFmt_t r;
        iFmt_t i;
    } instr_u;

    typedef struct packed {
        aluOp_e oper;
        logic   invA;   // Invert A before the units
        logic   invB;   // Invert B before the units
        logic   cin;    // Adder carry in
        logic   useImm; // B from immediate
    } aluCtrl_t;

    typedef struct packed {
        logic zero;
        logic ofl; // Signed overflow
        logic ltz; // Less than zero
    } aluFlags_t;

endpackage

/* src/aluDecode.sv */
// Combinational control decoder that turns an instruction word into ALU control and an immediate
`timescale 1ns/1ps

module aluDecode #(
    parameter int DATA_WIDTH = 16
) (
    input  aluPkg::instr_u        instr,
    output aluPkg::aluCtrl_t      ctrl,
    output logic [DATA_WIDTH-1:0] imm,
    output logic                  illegalOp
);
    import aluPkg::*;

    logic [IMM_WIDTH-1:0]  immField;
    logic [DATA_WIDTH-1:0] immZext;
    logic [DATA_WIDTH-1:0] immSext;

    assign immField = instr.i.imm; // I-format view of the word
    assign immZext  = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, immField}; // Logic ops and shift amounts
    assign immSext  = {{(DATA_WIDTH-IMM_WIDTH){immField[IMM_WIDTH-1]}}, immField}; // Add/sub

    always_comb begin
        ctrl      = '{oper: OP_ADD, invA: 1'b0, invB: 1'b0, cin: 1'b0, useImm: 1'b0}; // Safe add
        imm       = immZext;
        illegalOp = 1'b0;
        case (instr.r.opcode) // Opcode sits at the top in both views
            OPC_ALUR: begin
                case (instr.r.func)
                    2'b00: ctrl.oper = OP_ADD;
                    2'b01: begin // B minus A as ~A + B + 1
                        ctrl.oper = OP_ADD;
                        ctrl.invA = 1'b1;
                        ctrl.cin  = 1'b1;
                    end
                    2'b10: ctrl.oper = OP_XOR;
                    default: begin // ANDN
                        ctrl.oper = OP_AND;
                        ctrl.invB = 1'b1;
                    end
                endcase
            end
            OPC_SHIFTR: ctrl.oper = aluOp_e'({1'b0, instr.r.func}); // Func lines up with oper
            OPC_ADDI: begin
                ctrl.useImm = 1'b1;
                imm         = immSext;
            end
            OPC_SUBI: begin // Imm minus A
                ctrl.invA   = 1'b1;
                ctrl.cin    = 1'b1;
                ctrl.useImm = 1'b1;
                imm         = immSext;
            end
            OPC_XORI: begin
                ctrl.oper   = OP_XOR;
                ctrl.useImm = 1'b1;
            end
            OPC_ANDNI: begin
                ctrl.oper   = OP_AND;
                ctrl.invB   = 1'b1; // Inverts the zero-extended imm
                ctrl.useImm = 1'b1;
            end
            OPC_ROLI, OPC_SLLI, OPC_SRAI, OPC_SRLI: begin
                ctrl.oper   = aluOp_e'({1'b0, instr.i.opcode[1:0]}); // Low opcode bits pick shift
                ctrl.useImm = 1'b1;
            end
            default: illegalOp = 1'b1; // Keeps the add control
        endcase
    end

    // Inverting both sides would break every kept operation
    always_comb begin
        assert (!(ctrl.invA && ctrl.invB))
            else $error("aluDecode: invA and invB both set for opcode %b", instr.r.opcode);
    end

endmodule

/* src/claAdder.sv */
// Carry-lookahead adder built from 4-bit groups, with signed overflow, used by the ALU core
`timescale 1ns/1ps

module claAdder #(
    parameter int DATA_WIDTH = 16
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  logic                  cin,
    output logic [DATA_WIDTH-1:0] sum,
    output logic                  ofl
);
    localparam int NUM_GROUPS = DATA_WIDTH / 4;
    localparam int MSB        = DATA_WIDTH - 1;

    logic [DATA_WIDTH-1:0] p;     // Bit propagate
    logic [DATA_WIDTH-1:0] g;     // Bit generate
    logic [DATA_WIDTH-1:0] c;     // Carry into each bit
    logic [NUM_GROUPS:0]   grpC;  // Carry into each group

    assign p       = a ^ b;
    assign g       = a & b;
    assign grpC[0] = cin;

    for (genvar gi = 0; gi < NUM_GROUPS; gi++) begin : gGroup
        localparam int LSB = gi * 4;

        logic [3:0] gp;
        logic [3:0] gg;
        logic       grpP; // Group propagate
        logic       grpG; // Group generate

        assign gp = p[LSB +: 4];
        assign gg = g[LSB +: 4];

        // Lookahead within the group
        assign c[LSB]   = grpC[gi];
        assign c[LSB+1] = gg[0] | (gp[0] & grpC[gi]);
        assign c[LSB+2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & grpC[gi]);
        assign c[LSB+3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                        | (gp[2] & gp[1] & gp[0] & grpC[gi]);

        assign grpP = &gp;
        assign grpG = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                    | (gp[3] & gp[2] & gp[1] & gg[0]);

        assign grpC[gi+1] = grpG | (grpP & grpC[gi]); // Chain between groups
    end

    assign sum = p ^ c;

    // Like signs in, other sign out
    assign ofl = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);

endmodule

/* src/barrelShifter.sv */
// Logarithmic barrel shifter for rotate left and the three shifts, used by the ALU core
`timescale 1ns/1ps

module barrelShifter #(
    parameter int DATA_WIDTH = 16
) (
    input  logic [DATA_WIDTH-1:0]         in,
    input  logic [$clog2(DATA_WIDTH)-1:0] shAmt,
    input  logic [1:0]                    mode,  // Low bits of oper
    output logic [DATA_WIDTH-1:0]         out
);
    import aluPkg::*;

    localparam int SH_WIDTH = $clog2(DATA_WIDTH);
    localparam int MSB      = DATA_WIDTH - 1;

    logic [SH_WIDTH:0][DATA_WIDTH-1:0] stg; // Stage k holds the shift by shAmt[k-1:0]
    aluOp_e                            op;

    assign op     = aluOp_e'({1'b0, mode});
    assign stg[0] = in;

    for (genvar k = 0; k < SH_WIDTH; k++) begin : gStage
        localparam int S = 1 << k; // This stage moves by 2^k

        logic [S-1:0]          fillL;   // Enters at the bottom
        logic [S-1:0]          fillR;   // Enters at the top
        logic [DATA_WIDTH-1:0] shifted;

        assign fillL = (op == OP_ROL) ? stg[k][MSB -: S] : '0; // Wrap for rotate
        assign fillR = (op == OP_SRA) ? {S{stg[k][MSB]}} : '0; // Sign fill

        assign shifted = mode[1] ? {fillR, stg[k][MSB:S]}       // Right shifts
                                 : {stg[k][MSB-S:0], fillL};    // Left shift or rotate

        assign stg[k+1] = shAmt[k] ? shifted : stg[k];
    end

    assign out = stg[SH_WIDTH];

endmodule

/* src/aluCore.sv */
// Combinational ALU core with operand select and inversion, arithmetic, logic, shifts and flags
`timescale 1ns/1ps

module aluCore #(
    parameter int DATA_WIDTH = 16
) (
    input  aluPkg::aluCtrl_t      ctrl,
    input  logic [DATA_WIDTH-1:0] regA,
    input  logic [DATA_WIDTH-1:0] regB,
    input  logic [DATA_WIDTH-1:0] imm,
    output logic [DATA_WIDTH-1:0] aluResult,
    output aluPkg::aluFlags_t     aluFlags
);
    import aluPkg::*;

    localparam int SH_WIDTH = $clog2(DATA_WIDTH);
    localparam int MSB      = DATA_WIDTH - 1;

    logic [DATA_WIDTH-1:0] opB;      // Register or immediate
    logic [DATA_WIDTH-1:0] a;        // A after inversion
    logic [DATA_WIDTH-1:0] b;        // B after inversion
    logic [DATA_WIDTH-1:0] addOut;
    logic [DATA_WIDTH-1:0] andOut;
    logic [DATA_WIDTH-1:0] orOut;
    logic [DATA_WIDTH-1:0] xorOut;
    logic [DATA_WIDTH-1:0] logicOut; // Add/and/or/xor pick
    logic [DATA_WIDTH-1:0] shiftOut;
    logic                  addOfl;
    logic                  ofl;
    logic                  ltzRaw;   // Plain sign of the result

    // Operand select and inversion
    assign opB = ctrl.useImm ? imm : regB;
    assign a   = ctrl.invA ? ~regA : regA;
    assign b   = ctrl.invB ? ~opB : opB;

    claAdder #(
        .DATA_WIDTH(DATA_WIDTH)
    ) adder0 (
        .a   (a),
        .b   (b),
        .cin (ctrl.cin),
        .sum (addOut),
        .ofl (addOfl)
    );

    barrelShifter #(
        .DATA_WIDTH(DATA_WIDTH)
    ) shifter0 (
        .in    (a),
        .shAmt (b[SH_WIDTH-1:0]), // Low bits of B give the amount
        .mode  (ctrl.oper[1:0]),
        .out   (shiftOut)
    );

    // Bitwise units
    assign andOut = a & b;
    assign orOut  = a | b;
    assign xorOut = a ^ b;

    always_comb begin
        case (ctrl.oper[1:0])
            2'b00:   logicOut = addOut;
            2'b01:   logicOut = andOut;
            2'b10:   logicOut = orOut;
            default: logicOut = xorOut;
        endcase
    end

    assign aluResult = ctrl.oper[2] ? logicOut : shiftOut; // Top oper bit low means shift

    // Overflow only counts for add, gated bit by bit
    assign ofl = ctrl.oper[2] & ~ctrl.oper[1] & ~ctrl.oper[0] & addOfl;

    assign ltzRaw = aluResult[MSB];

    always_comb begin
        aluFlags.zero = ~|aluResult;
        aluFlags.ofl  = ofl;
        aluFlags.ltz  = (ofl && (aluResult[MSB] != a[MSB])) ? ~ltzRaw : ltzRaw; // Sign fix
    end

    // The adder's overflow must not leak into logic or shift results
    always_comb begin
        assert (!(aluFlags.ofl && (ctrl.oper != OP_ADD)))
            else $error("aluCore: ofl set for oper %0d", ctrl.oper);
    end

endmodule

/* src/execUnit.sv */
// Execute stage top level: decode, ALU core and a one-cycle output register
`timescale 1ns/1ps

module execUnit #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid,  // One-cycle strobe per item
    input  aluPkg::instr_u        instr,
    input  logic [DATA_WIDTH-1:0] regA,
    input  logic [DATA_WIDTH-1:0] regB,
    output logic                  outValid,
    output logic [DATA_WIDTH-1:0] result,
    output aluPkg::aluFlags_t     flags,
    output logic                  illegal
);
    import aluPkg::*;

    aluCtrl_t              ctrl;
    logic [DATA_WIDTH-1:0] imm;
    logic                  illegalOp;
    logic [DATA_WIDTH-1:0] aluResult;
    aluFlags_t             aluFlags;

    aluDecode #(
        .DATA_WIDTH(DATA_WIDTH)
    ) decode0 (
        .instr     (instr),
        .ctrl      (ctrl),
        .imm       (imm),
        .illegalOp (illegalOp)
    );

    aluCore #(
        .DATA_WIDTH(DATA_WIDTH)
    ) core0 (
        .ctrl      (ctrl),
        .regA      (regA),
        .regB      (regB),
        .imm       (imm),
        .aluResult (aluResult),
        .aluFlags  (aluFlags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            result   <= '0;
            flags    <= '0;
            illegal  <= 1'b0;
        end else begin
            outValid <= inValid;
            if (inValid) begin // Hold between strobes
                result  <= illegalOp ? '0 : aluResult; // Squash unknown opcodes
                flags   <= illegalOp ? '0 : aluFlags;
                illegal <= illegalOp;
            end
        end
    end

    // Illegal items leave nothing behind in the payload
    assert property (@(posedge clk) disable iff (rst) illegal |-> (result == '0 && flags == '0))
        else $error("execUnit: illegal with nonzero result %h", result);

endmodule

/* verification/execChecker.sv */
// Testbench checker that compares execute stage outputs with expectations delayed by one cycle
`timescale 1ns/1ps

module execChecker #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  outValid,
    input  logic [DATA_WIDTH-1:0] result,
    input  aluPkg::aluFlags_t     flags,
    input  logic                  illegal,
    input  logic                  expValid,   // Driven with the row, same cycle as inValid
    input  logic [DATA_WIDTH-1:0] expResult,
    input  aluPkg::aluFlags_t     expFlags,
    input  logic                  expIllegal,
    output int                    checkedCount,
    output int                    errorCount
);
    import aluPkg::*;

    logic                  validQ;  // Expectations lined up with DUT latency
    logic [DATA_WIDTH-1:0] resultQ;
    aluFlags_t             flagsQ;
    logic                  illegalQ;

    initial begin
        checkedCount = 0;
        errorCount   = 0;
    end

    always @(posedge clk) begin
        validQ   <= rst ? 1'b0 : expValid;
        resultQ  <= expResult;
        flagsQ   <= expFlags;
        illegalQ <= expIllegal;
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        int bad;
        bad = 0;
        if (rst) begin
            if (outValid !== 1'b0) begin // Must stay quiet in reset
                $display("Error: outValid not low during reset");
                errorCount = errorCount + 1;
            end
        end else if (outValid !== validQ) begin
            $display("Error: outValid is %b but one cycle after input strobe expected %b",
                     outValid, validQ);
            errorCount = errorCount + 1;
        end else if (outValid) begin
            if (result !== resultQ) begin
                $display("Mismatch result: got %h expected %h", result, resultQ);
                bad = bad + 1;
            end
            if (flags !== flagsQ) begin
                $display("Mismatch flags: got %h expected %h", flags, flagsQ);
                bad = bad + 1;
            end
            if (illegal !== illegalQ) begin
                $display("Mismatch illegal: got %h expected %h", illegal, illegalQ);
                bad = bad + 1;
            end
            if (bad == 0)
                $display("Test %0d ok: result %h flags %h", checkedCount, result, flags);
            else
                $display("Test %0d FAILED with %0d wrong signals", checkedCount, bad);
            checkedCount = checkedCount + 1;
            if (bad != 0)
                errorCount = errorCount + 1;
        end
    end

endmodule

/* verification/tbExecUnit.sv */
// Testbench top for the execute stage, applies a stimulus table one row per cycle
`timescale 1ns/1ps

module tbExecUnit;
    import aluPkg::*;

    localparam int DATA_WIDTH = 16;
    localparam int HAND_ROWS  = 21;
    localparam int NUM_ROWS   = HAND_ROWS + 8;
    localparam int RST_CYCLES = 5;
    localparam int LIMIT      = RST_CYCLES + NUM_ROWS + 20; // Cycle budget

    logic clk = 1'b0;
    logic rst, inValid, outValid, illegal;
    instr_u instr;
    logic [DATA_WIDTH-1:0] regA, regB, result;
    aluFlags_t flags;
    logic expValid, expIllegal;
    logic [DATA_WIDTH-1:0] expResult;
    aluFlags_t expFlags;
    int checkedCount, errorCount;
    int cycles = 0;
    integer seed = 32'h1779_06ff;

    instr_u                tInstr[NUM_ROWS];
    logic [DATA_WIDTH-1:0] tA[NUM_ROWS], tB[NUM_ROWS], tRes[NUM_ROWS];
    aluFlags_t             tFlags[NUM_ROWS];
    logic                  tIll[NUM_ROWS];
    int                    fill = 0;

    always #5 clk = ~clk; // 10 ns period

    execUnit #(.DATA_WIDTH(DATA_WIDTH)) dut0 (
        .clk(clk), .rst(rst), .inValid(inValid), .instr(instr), .regA(regA), .regB(regB),
        .outValid(outValid), .result(result), .flags(flags), .illegal(illegal)
    );

    execChecker #(.DATA_WIDTH(DATA_WIDTH)) checker0 (
        .clk(clk), .rst(rst), .outValid(outValid), .result(result), .flags(flags),
        .illegal(illegal), .expValid(expValid), .expResult(expResult), .expFlags(expFlags),
        .expIllegal(expIllegal), .checkedCount(checkedCount), .errorCount(errorCount)
    );

    function automatic logic [15:0] rInstr(logic [4:0] opc, logic [1:0] func);
        return {opc, 9'b0, func};
    endfunction

    function automatic logic [15:0] iInstr(logic [4:0] opc, logic [4:0] imm5);
        return {opc, 6'b0, imm5};
    endfunction

    task automatic addRow(logic [15:0] ins, logic [15:0] a, logic [15:0] b,
                          logic [15:0] res, logic [2:0] fl, logic ill);
        tInstr[fill] = ins;
        tA[fill]     = a;
        tB[fill]     = b;
        tRes[fill]   = res;
        tFlags[fill] = fl;
        tIll[fill]   = ill;
        fill         = fill + 1;
    endtask

    // Shift definitions: 0 rol, 1 sll, 2 sra, 3 srl
    function automatic logic [15:0] shiftModel(logic [1:0] kind, logic [15:0] a, logic [3:0] n);
        logic [31:0]        both;
        logic signed [15:0] sa;
        both = {a, a} << n;
        sa   = a;
        case (kind)
            2'd0:    return both[31:16];
            2'd1:    return a << n;
            2'd2:    return sa >>> n;
            default: return a >> n;
        endcase
    endfunction

    // Expected values straight from the instruction set rules
    task automatic expectRow(logic [15:0] ins, logic [15:0] a, logic [15:0] b,
                             output logic [15:0] res, output logic [2:0] fl, output logic ill);
        logic [4:0]  opc;
        logic [15:0] sext, zext;
        int          exact;
        logic        arith, ofl, ltz;
        opc   = ins[15:11];
        zext  = {11'b0, ins[4:0]};
        sext  = {{11{ins[4]}}, ins[4:0]};
        arith = (opc == 5'b11011 && !ins[1]) || opc == 5'b01000 || opc == 5'b01001; // Add, sub
        exact = 0;
        ill   = 1'b0;
        res   = '0;
        case (opc)
            5'b11011: begin
                case (ins[1:0])
                    2'd0:    exact = int'($signed(a)) + int'($signed(b));
                    2'd1:    exact = int'($signed(b)) - int'($signed(a));
                    2'd2:    res = a ^ b;
                    default: res = a & ~b;
                endcase
            end
            5'b11010: res = shiftModel(ins[1:0], a, b[3:0]);
            5'b01000: exact = int'($signed(a)) + int'($signed(sext));
            5'b01001: exact = int'($signed(sext)) - int'($signed(a));
            5'b01010: res = a ^ zext;
            5'b01011: res = a & ~zext;
            5'b10100, 5'b10101, 5'b10110, 5'b10111: res = shiftModel(opc[1:0], a, zext[3:0]);
            default: ill = 1'b1;
        endcase
        if (arith) begin
            res = exact[15:0];
            ofl = (exact > 32767) || (exact < -32768);
            ltz = exact < 0; // True sign even on overflow
        end else begin
            ofl = 1'b0;
            ltz = res[15];
        end
        fl = ill ? 3'b000 : {res == 16'h0, ofl, ltz};
    endtask

    task automatic addRandomRows();
        logic [15:0] pool[16];
        logic [15:0] ins, a, b, res;
        logic [31:0] r;
        logic [2:0]  fl;
        logic        ill;
        for (int k = 0; k < 4; k++) begin
            pool[k]     = rInstr(5'b11011, k[1:0]);
            pool[k + 4] = rInstr(5'b11010, k[1:0]);
            pool[k + 8] = iInstr(5'b01000 + k[4:0], 5'b0);
            pool[k + 12] = iInstr(5'b10100 + k[4:0], 5'b0);
        end
        for (int k = 0; k < NUM_ROWS - HAND_ROWS; k++) begin
            r   = $random(seed);
            ins = pool[r[3:0]];
            ins[4:0] = ins[15] & ins[14] ? ins[4:0] : r[8:4]; // Random imm for I-format only
            r   = $random(seed);
            a   = r[15:0];
            b   = r[31:16];
            expectRow(ins, a, b, res, fl, ill);
            addRow(ins, a, b, res, fl, ill);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: results did not all arrive within %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        inValid    = 1'b0;
        instr      = '0;
        regA       = '0;
        regB       = '0;
        expValid   = 1'b0;
        expResult  = '0;
        expFlags   = '0;
        expIllegal = 1'b0;
        // Flags column is {zero, ofl, ltz}
        addRow(rInstr(5'b11011, 2'd0), 16'h0003, 16'h0004, 16'h0007, 3'b000, 1'b0);
        addRow(rInstr(5'b11011, 2'd0), 16'h7fff, 16'h0001, 16'h8000, 3'b010, 1'b0);
        addRow(rInstr(5'b11011, 2'd1), 16'h0005, 16'h0005, 16'h0000, 3'b100, 1'b0);
        addRow(rInstr(5'b11011, 2'd1), 16'h0005, 16'h0003, 16'hfffe, 3'b001, 1'b0);
        addRow(rInstr(5'b11011, 2'd1), 16'h0001, 16'h8000, 16'h7fff, 3'b011, 1'b0);
        addRow(iInstr(5'b01000, 5'h1f), 16'h0010, 16'h0000, 16'h000f, 3'b000, 1'b0);
        addRow(iInstr(5'b01001, 5'h03), 16'h0005, 16'h0000, 16'hfffe, 3'b001, 1'b0);
        addRow(rInstr(5'b11011, 2'd2), 16'hff00, 16'h0ff0, 16'hf0f0, 3'b001, 1'b0);
        addRow(rInstr(5'b11011, 2'd3), 16'hffff, 16'h00ff, 16'hff00, 3'b001, 1'b0);
        addRow(iInstr(5'b01010, 5'h15), 16'h1234, 16'h0000, 16'h1221, 3'b000, 1'b0);
        addRow(iInstr(5'b01011, 5'h1f), 16'h00ff, 16'h0000, 16'h00e0, 3'b000, 1'b0);
        addRow(rInstr(5'b11010, 2'd0), 16'h8001, 16'h0001, 16'h0003, 3'b000, 1'b0);
        addRow(rInstr(5'b11010, 2'd1), 16'h0001, 16'h000f, 16'h8000, 3'b001, 1'b0);
        addRow(rInstr(5'b11010, 2'd2), 16'h8000, 16'h0007, 16'hff00, 3'b001, 1'b0);
        addRow(rInstr(5'b11010, 2'd3), 16'h8000, 16'h000f, 16'h0001, 3'b000, 1'b0);
        addRow(iInstr(5'b10100, 5'h07), 16'h1234, 16'h0000, 16'h1a09, 3'b000, 1'b0);
        addRow(iInstr(5'b10101, 5'h00), 16'habcd, 16'h0000, 16'habcd, 3'b001, 1'b0);
        addRow(iInstr(5'b10110, 5'h0f), 16'h7fff, 16'h0000, 16'h0000, 3'b100, 1'b0);
        addRow(iInstr(5'b10111, 5'h01), 16'h8000, 16'h0000, 16'h4000, 3'b000, 1'b0);
        addRow(iInstr(5'b00000, 5'h00), 16'h0001, 16'h0002, 16'h0000, 3'b000, 1'b1);
        addRow(rInstr(5'b11011, 2'd2), 16'h1234, 16'h1234, 16'h0000, 3'b100, 1'b0);
        addRandomRows();

        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        for (int k = 0; k < NUM_ROWS; k++) begin // Back to back, one row per cycle
            @(posedge clk);
            #1;
            inValid    = 1'b1;
            instr      = tInstr[k];
            regA       = tA[k];
            regB       = tB[k];
            expValid   = 1'b1;
            expResult  = tRes[k];
            expFlags   = tFlags[k];
            expIllegal = tIll[k];
        end
        @(posedge clk);
        #1;
        inValid  = 1'b0;
        expValid = 1'b0;
        wait (checkedCount == NUM_ROWS);
        repeat (2) @(posedge clk);
        $display("Counts: %0d rows, %0d checked, %0d errors", NUM_ROWS, checkedCount, errorCount);
        if (errorCount == 0 && checkedCount == NUM_ROWS)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verilog.f */
src/aluPkg.sv
src/aluDecode.sv
src/claAdder.sv
src/barrelShifter.sv
src/aluCore.sv
src/execUnit.sv
verification/execChecker.sv
verification/tbExecUnit.sv

/* run.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and search for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tbExecUnit -Mdir obj_dir &&
./obj_dir/VtbExecUnit | tee /dev/stderr | grep -qx "Test passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }
